/* flist.f */
+incdir+.
bcu_pkg.sv
cache_req_if.sv
ifetch_port.sv
dcache_port.sv
mem_sequencer.sv
bcu_top.sv
bcu_assert.sv
bcu_tb.sv

/* Makefile */
TOP = bcu_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

obj_dir/V$(TOP): flist.f *.sv *.svh
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	@grep -qF "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

/* bcu_tb.sv */
// bus control unit testbench with clock, reset, memory model, directed tests and final report
`timescale 1ns/1ns

module bcu_tb import bcu_pkg::*; ();

	localparam int         TIMEOUT   = 200;            // cycles allowed per wait
	localparam data_word_t RD_XOR    = 32'hA5A5_0000;  // model read data pattern

	logic       sys_clk;
	logic       reset;
	mem_addr_t  icache_address;
	logic       icache_request_n;
	logic       icache_done_n;
	data_word_t cache_dbus;
	mem_addr_t  dcache_address;
	logic       dcache_request_n;
	logic       dcache_done_n;
	logic       write_size;
	data_word_t write_data;
	logic       write_request_n;
	logic       write_accept_n;
	mem_addr_t  mem_address;
	data_word_t mem_busout;
	mem_cmd_t   mem_control;
	lane_mask_t mem_valid;
	data_word_t mem_busin;
	logic       mem_ack;
	logic       start_shutdown;
	logic       finished_shutdown;

	// memory model
	integer     seed;
	logic       mem_hold;      // holds off acks so writes pile up
	mem_addr_t  rd_q[$];       // read addresses seen on the bus
	mem_addr_t  wr_addr_q[$];  // writes in bus order
	data_word_t wr_data_q[$];
	lane_mask_t wr_mask_q[$];

	int errors;
	int test_start;
	int tests;
	int tests_failed;

	bcu_top u_bcu_top (.*);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	// --------------------------------------------------
	// memory model acking after 1 to 6 cycles
	// --------------------------------------------------

	always begin : mem_model
		int delay;
		@(posedge sys_clk);
		if (!reset && mem_control != cmd_nop && !mem_hold) begin
			delay = 1 + int'($unsigned($random(seed)) % 6);
			repeat (delay - 1) @(posedge sys_clk);
			#5;
			mem_ack   = 1'b1;
			mem_busin = mem_address ^ RD_XOR;
			if (mem_control == cmd_write) begin
				wr_addr_q.push_back(mem_address);
				wr_data_q.push_back(mem_busout);
				wr_mask_q.push_back(mem_valid);
			end else begin
				rd_q.push_back(mem_address);
			end
			@(posedge sys_clk);
			#5;
			mem_ack = 1'b0; // one cycle ack
		end
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------

	task automatic tick();
		@(posedge sys_clk);
		#5; // drive and sample off the edge
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		errors++;
	endtask

	// word the model returns for a read of this aligned address
	function automatic data_word_t expected_read(input mem_addr_t addr);
		return addr ^ RD_XOR;
	endfunction

	// one cycle request pulses on either or both caches
	task automatic request_reads(input bit do_i, input mem_addr_t ia,
		input bit do_d, input mem_addr_t da);
		icache_address   = ia;
		dcache_address   = da;
		icache_request_n = !do_i;
		dcache_request_n = !do_d;
		tick();
		icache_request_n = 1'b1;
		dcache_request_n = 1'b1;
	endtask

	task automatic wait_done(input bit data_side, output data_word_t dbus);
		int n;
		n = 0;
		while ((data_side ? dcache_done_n : icache_done_n) !== 1'b0 && n < TIMEOUT) begin
			tick();
			n++;
		end
		if (n >= TIMEOUT)
			report_timeout(data_side ? "dcache_done_n" : "icache_done_n");
		dbus = cache_dbus; // valid in the done cycle only
	endtask

	// request held until accept and the cycles waited handed back
	task automatic write_through(input bit size, input mem_addr_t addr,
		input data_word_t data, output int waited);
		write_size      = size;
		dcache_address  = addr;
		write_data      = data;
		write_request_n = 1'b0;
		tick();
		waited = 1;
		while (write_accept_n !== 1'b0 && waited < TIMEOUT) begin
			tick();
			waited++;
		end
		if (write_accept_n !== 1'b0)
			report_timeout("write_accept_n");
		write_request_n = 1'b1;
	endtask

	task automatic wait_writes(input int count);
		int n;
		n = 0;
		while (wr_addr_q.size() < count && n < TIMEOUT) begin
			tick();
			n++;
		end
		if (wr_addr_q.size() < count)
			report_timeout("buffered writes to reach memory");
	endtask

	task automatic check_write(input int idx, input mem_addr_t addr,
		input data_word_t data, input lane_mask_t mask);
		check_value("mem_address", wr_addr_q[idx], addr);
		check_value("mem_busout", wr_data_q[idx], data);
		check_value("mem_valid", 32'(wr_mask_q[idx]), 32'(mask));
	endtask

	// no done pulse, no accept and an idle bus
	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			tick();
			check_value("icache_done_n", 32'(icache_done_n), 32'd1);
			check_value("dcache_done_n", 32'(dcache_done_n), 32'd1);
			check_value("write_accept_n", 32'(write_accept_n), 32'd1);
			check_value("mem_control", 32'(mem_control), 32'(cmd_nop));
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_start) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests, name, errors - test_start);
		end
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------

	initial begin
		data_word_t dbus_i;
		data_word_t dbus_d;
		int rd_base;
		int wr_base;
		int waited;
		int n;
		int total;
		seed             = 75;
		errors           = 0;
		tests            = 0;
		tests_failed     = 0;
		reset            = 1'b1;
		icache_address   = '0;
		icache_request_n = 1'b1;
		dcache_address   = '0;
		dcache_request_n = 1'b1;
		write_size       = 1'b0;
		write_data       = '0;
		write_request_n  = 1'b1;
		start_shutdown   = 1'b0;
		mem_busin        = '0;
		mem_ack          = 1'b0;
		mem_hold         = 1'b0;
		repeat (16) tick();
		reset = 1'b0;
		tick();

		// unaligned instruction read
		test_start = errors;
		rd_base    = rd_q.size();
		request_reads(1'b1, 32'h0000_1234, 1'b0, '0);
		wait_done(1'b0, dbus_i);
		check_value("read count", rd_q.size(), rd_base + 1);
		check_value("mem_address", rd_q[rd_base], 32'h0000_1230);
		check_value("cache_dbus", dbus_i, expected_read(32'h0000_1230));
		check_idle(6); // single done pulse
		end_test("instruction read");

		// data read alone and then both caches in one cycle
		test_start = errors;
		rd_base    = rd_q.size();
		request_reads(1'b0, '0, 1'b1, 32'h0000_2468);
		wait_done(1'b1, dbus_d);
		check_value("cache_dbus", dbus_d, expected_read(32'h0000_2460));
		request_reads(1'b1, 32'h0000_3005, 1'b1, 32'h0000_400c);
		wait_done(1'b0, dbus_i);
		wait_done(1'b1, dbus_d);
		check_value("read count", rd_q.size(), rd_base + 3);
		check_value("mem_address", rd_q[rd_base + 1], 32'h0000_3000); // ifetch first
		check_value("mem_address", rd_q[rd_base + 2], 32'h0000_4000);
		check_value("cache_dbus", dbus_i, expected_read(32'h0000_3000));
		check_value("cache_dbus", dbus_d, expected_read(32'h0000_4000));
		end_test("data read and priority");

		// byte write on each lane and then a word write
		test_start = errors;
		wr_base    = wr_addr_q.size();
		for (int k = 0; k < 4; k++)
			write_through(1'b0, 32'h0000_5010 + k, 32'h1234_5600 | (32'hA0 + k), waited);
		write_through(1'b1, 32'h0000_5017, 32'hDEAD_BEEF, waited);
		wait_writes(wr_base + 5);
		for (int k = 0; k < 4; k++)
			check_write(wr_base + k, 32'h0000_5010 + k, (32'hA0 + k) << (8 * k), 4'b0001 << k);
		check_write(wr_base + 4, 32'h0000_5014, 32'hDEAD_BEEF, 4'b1111);
		end_test("write lanes");

		// six writes against a stalled memory so the fifth waits for room
		test_start = errors;
		wr_base    = wr_addr_q.size();
		mem_hold   = 1'b1;
		for (int k = 0; k < 4; k++)
			write_through(1'b1, 32'h0000_6000 + 4 * k, 32'h6000_0000 + k, waited);
		fork
			begin
				repeat (8) tick();
				mem_hold = 1'b0;
			end
		join_none
		write_through(1'b1, 32'h0000_6010, 32'h6000_0004, waited);
		assert (waited > 8) else begin
			$display("FAILED write_accept_n came after %h cycles expected more than %h",
				waited, 8);
			errors++;
		end
		write_through(1'b1, 32'h0000_6014, 32'h6000_0005, waited);
		wait_writes(wr_base + 6);
		for (int k = 0; k < 6; k++)
			check_write(wr_base + k, 32'h0000_6000 + 4 * k, 32'h6000_0000 + k, 4'b1111);
		end_test("write buffer back-pressure");

		// data read queued behind three writes
		test_start = errors;
		wr_base    = wr_addr_q.size();
		mem_hold   = 1'b1;
		for (int k = 0; k < 3; k++)
			write_through(1'b1, 32'h0000_7000 + 4 * k, 32'h7000_0000 + k, waited);
		request_reads(1'b0, '0, 1'b1, 32'h0000_7123);
		mem_hold = 1'b0;
		wait_done(1'b1, dbus_d);
		check_value("write count", wr_addr_q.size(), wr_base + 3);
		check_value("mem_address", rd_q[rd_q.size() - 1], 32'h0000_7120);
		check_value("cache_dbus", dbus_d, expected_read(32'h0000_7120));
		end_test("read behind writes");

		// shutdown with writes buffered and both reads pending
		test_start = errors;
		wr_base    = wr_addr_q.size();
		rd_base    = rd_q.size();
		mem_hold   = 1'b1;
		for (int k = 0; k < 3; k++)
			write_through(1'b1, 32'h0000_8000 + 4 * k, 32'h8000_0000 + k, waited);
		request_reads(1'b1, 32'h0000_9000, 1'b1, 32'h0000_a000);
		start_shutdown = 1'b1;
		tick();
		start_shutdown = 1'b0;
		mem_hold       = 1'b0;
		n = 0;
		while (finished_shutdown !== 1'b1 && n < TIMEOUT) begin
			check_value("icache_done_n", 32'(icache_done_n), 32'd1);
			check_value("dcache_done_n", 32'(dcache_done_n), 32'd1);
			tick();
			n++;
		end
		if (finished_shutdown !== 1'b1)
			report_timeout("finished_shutdown");
		check_value("write count", wr_addr_q.size(), wr_base + 3);
		check_value("read count", rd_q.size(), rd_base); // reads dropped
		// requests after the halt go nowhere
		request_reads(1'b1, 32'h0000_b000, 1'b1, 32'h0000_c000);
		write_size      = 1'b1;
		dcache_address  = 32'h0000_d000;
		write_request_n = 1'b0;
		check_idle(10);
		write_request_n = 1'b1;
		check_value("finished_shutdown", 32'(finished_shutdown), 32'd1);
		check_value("write count", wr_addr_q.size(), wr_base + 3);
		check_value("read count", rd_q.size(), rd_base);
		end_test("shutdown");

		total = errors + u_bcu_top.u_bcu_assert.assert_fails;
		$display("tests %0d, failed %0d, errors %0d", tests, tests_failed, total);
		if (total == 0 && tests_failed == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* bcu_assert.sv */
// protocol checks on the bus control unit pins, bound into the top level
`timescale 1ns/1ns

module bcu_assert import bcu_pkg::*; (
	input logic       sys_clk,
	input logic       reset,
	input logic       icache_done_n,
	input logic       dcache_done_n,
	input logic       write_request_n,
	input logic       write_accept_n,
	input mem_cmd_t   mem_control,
	input mem_addr_t  mem_address,
	input data_word_t mem_busout,
	input lane_mask_t mem_valid,
	input logic       mem_ack,
	input logic       finished_shutdown
);

	int assert_fails = 0; // failed checks so far

	// --------------------------------------------------
	// memory bus
	// --------------------------------------------------

	// command and its fields frozen until ack
	cmd_stable: assert property (@(posedge sys_clk) disable iff (reset)
		(mem_control != cmd_nop && !mem_ack) |=>
		($stable(mem_control) && $stable(mem_address) &&
		$stable(mem_busout) && $stable(mem_valid)))
	else begin
		$error("memory command changed before mem_ack");
		assert_fails++;
	end

	// cache side strobes
	idone_pulse: assert property (@(posedge sys_clk) disable iff (reset)
		!icache_done_n |=> icache_done_n)
	else begin
		$error("icache_done_n low for more than one cycle");
		assert_fails++;
	end

	ddone_pulse: assert property (@(posedge sys_clk) disable iff (reset)
		!dcache_done_n |=> dcache_done_n)
	else begin
		$error("dcache_done_n low for more than one cycle");
		assert_fails++;
	end

	// accept answers a request seen one cycle earlier
	accept_req: assert property (@(posedge sys_clk) disable iff (reset)
		!write_accept_n |-> $past(!write_request_n))
	else begin
		$error("write accepted with no write request held");
		assert_fails++;
	end

	// halted unit stays quiet
	halt_quiet: assert property (@(posedge sys_clk) disable iff (reset)
		finished_shutdown |-> (mem_control == cmd_nop))
	else begin
		$error("memory command after shutdown finished");
		assert_fails++;
	end

	halt_sticky: assert property (@(posedge sys_clk) disable iff (reset)
		finished_shutdown |=> finished_shutdown)
	else begin
		$error("finished_shutdown dropped before reset");
		assert_fails++;
	end

endmodule

bind bcu_top bcu_assert u_bcu_assert (
	.sys_clk           (sys_clk),
	.reset             (reset),
	.icache_done_n     (icache_done_n),
	.dcache_done_n     (dcache_done_n),
	.write_request_n   (write_request_n),
	.write_accept_n    (write_accept_n),
	.mem_control       (mem_control),
	.mem_address       (mem_address),
	.mem_busout        (mem_busout),
	.mem_valid         (mem_valid),
	.mem_ack           (mem_ack),
	.finished_shutdown (finished_shutdown)
);

/* bcu_top.sv */
// bus control unit top level: cache side and memory bus pins, port and sequencer instances
`timescale 1ns/1ns

module bcu_top import bcu_pkg::*; (
	input  logic       sys_clk,
	input  logic       reset,

	// instruction cache
	input  mem_addr_t  icache_address,
	input  logic       icache_request_n,
	output logic       icache_done_n,
	output data_word_t cache_dbus,       // shared read data to both caches

	// data cache
	input  mem_addr_t  dcache_address,
	input  logic       dcache_request_n,
	output logic       dcache_done_n,
	input  logic       write_size,       // 0 byte, 1 word
	input  data_word_t write_data,
	input  logic       write_request_n,
	output logic       write_accept_n,

	// memory bus
	output mem_addr_t  mem_address,
	output data_word_t mem_busout,
	output mem_cmd_t   mem_control,
	output lane_mask_t mem_valid,
	input  data_word_t mem_busin,
	input  logic       mem_ack,

	// shutdown
	input  logic       start_shutdown,
	output logic       finished_shutdown
);

	data_word_t ifetch_dbus;
	data_word_t dcache_dbus;

	cache_req_if if_ifetch ();
	cache_req_if if_dcache ();

	ifetch_port u_ifetch_port (
		.sys_clk          (sys_clk),
		.reset            (reset),
		.icache_address   (icache_address),
		.icache_request_n (icache_request_n),
		.icache_done_n    (icache_done_n),
		.cache_dbus       (ifetch_dbus),
		.req              (if_ifetch.port)
	);

	dcache_port u_dcache_port (
		.sys_clk          (sys_clk),
		.reset            (reset),
		.dcache_address   (dcache_address),
		.dcache_request_n (dcache_request_n),
		.write_size       (write_size),
		.write_data       (write_data),
		.write_request_n  (write_request_n),
		.dcache_done_n    (dcache_done_n),
		.dcache_dbus      (dcache_dbus),
		.write_accept_n   (write_accept_n),
		.req              (if_dcache.port)
	);

	mem_sequencer u_mem_sequencer (
		.sys_clk           (sys_clk),
		.reset             (reset),
		.start_shutdown    (start_shutdown),
		.mem_busin         (mem_busin),
		.mem_ack           (mem_ack),
		.mem_address       (mem_address),
		.mem_busout        (mem_busout),
		.mem_control       (mem_control),
		.mem_valid         (mem_valid),
		.finished_shutdown (finished_shutdown),
		.ifetch            (if_ifetch.sequencer),
		.dcache            (if_dcache.sequencer)
	);

	// done cycles never overlap, data side wins its own cycle
	assign cache_dbus = !dcache_done_n ? dcache_dbus : ifetch_dbus;

endmodule

/* mem_sequencer.sv */
// memory sequencer: port arbitration, memory bus driver, read data return and shutdown FSM
`timescale 1ns/1ns

module mem_sequencer import bcu_pkg::*; (
	input  logic            sys_clk,
	input  logic            reset,
	input  logic            start_shutdown,    // one cycle pulse
	input  data_word_t      mem_busin,
	input  logic            mem_ack,           // one cycle high, ends the command
	output mem_addr_t       mem_address,
	output data_word_t      mem_busout,
	output mem_cmd_t        mem_control,
	output lane_mask_t      mem_valid,
	output logic            finished_shutdown,
	cache_req_if.sequencer  ifetch,
	cache_req_if.sequencer  dcache
);

	seq_state_t state;
	customer_t  owner;  // who holds the bus, none when idle
	customer_t  pick;   // next owner, none if nothing to start
	logic       issue;
	logic       shut;   // drain or halted
	logic       drain_done;

	// selected request fields
	logic       pick_write;
	mem_addr_t  pick_addr;
	data_word_t pick_wdata;
	lane_mask_t pick_mask;

	assign shut = (state == seq_drain) || (state == seq_halted);

	// --------------------------------------------------
	// arbitration: ifetch read, data read, buffered write
	// --------------------------------------------------

	always_comb begin
		pick = cust_none;
		if (state == seq_idle && !start_shutdown) begin
			if (ifetch.valid)
				pick = cust_ifetch;
			else if (dcache.valid && !dcache.write)
				pick = cust_dread;
			else if (dcache.valid)
				pick = cust_dwrite;
		end else if (state == seq_drain && owner == cust_none) begin
			if (dcache.valid && dcache.write)
				pick = cust_dwrite; // draining, writes only
		end
	end

	assign issue = (pick != cust_none);

	always_comb begin
		if (pick == cust_ifetch) begin
			pick_write = ifetch.write;
			pick_addr  = ifetch.addr;
			pick_wdata = ifetch.wdata;
			pick_mask  = ifetch.mask;
		end else begin
			pick_write = dcache.write;
			pick_addr  = dcache.addr;
			pick_wdata = dcache.wdata;
			pick_mask  = dcache.mask;
		end
	end

	// FSM and command
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			state       <= seq_idle;
			owner       <= cust_none;
			mem_control <= cmd_nop;
		end else begin
			if (owner != cust_none && mem_ack) begin
				mem_control <= cmd_nop; // nop in the cycle after ack
				owner       <= cust_none;
				if (state == seq_busy)
					state <= seq_idle;
			end else if (issue) begin
				mem_control <= pick_write ? cmd_write : cmd_read;
				owner       <= pick;
				if (state == seq_idle)
					state <= seq_busy;
			end
			// a transaction on the bus is kept, only its done is lost
			if (start_shutdown && !shut)
				state <= seq_drain;
			if (drain_done)
				state <= seq_halted;
		end
	end

	// address, data and lanes ride with the command
	always_ff @(posedge sys_clk) begin
		if (issue) begin
			mem_address <= pick_addr;
			mem_busout  <= pick_wdata;
			mem_valid   <= pick_mask;
		end
	end

	// --------------------------------------------------
	// port side returns
	// --------------------------------------------------

	// reads that complete during shutdown get no grant
	assign ifetch.grant = mem_ack && owner == cust_ifetch && !shut;
	assign dcache.grant = mem_ack && (owner == cust_dwrite ||
		(owner == cust_dread && !shut));
	assign ifetch.rdata = mem_busin;
	assign dcache.rdata = mem_busin;
	assign ifetch.abort = shut;
	assign dcache.abort = shut;

	// bus idle and buffer empty, flag shows in the cycle after the last ack
	assign drain_done        = (state == seq_drain) && owner == cust_none &&
		!(dcache.valid && dcache.write);
	assign finished_shutdown = drain_done || (state == seq_halted);

endmodule

/* dcache_port.sv */
// data cache port: pending data read, lane steering write buffer and write accept handshake
`timescale 1ns/1ns
`include "bcu_params.svh"

module dcache_port import bcu_pkg::*; (
	input  logic       sys_clk,
	input  logic       reset,
	input  mem_addr_t  dcache_address,   // read and write address
	input  logic       dcache_request_n, // read, one cycle low pulse
	input  logic       write_size,       // 0 byte, 1 word
	input  data_word_t write_data,
	input  logic       write_request_n,  // held low until accept
	output logic       dcache_done_n,
	output data_word_t dcache_dbus,
	output logic       write_accept_n,
	cache_req_if.port  req
);

	localparam int DEPTH = `BCU_WBUF_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam mem_addr_t READ_MASK = ~mem_addr_t'((1 << `BCU_LINE_BITS) - 1);

	// --------------------------------------------------
	// read side state
	// --------------------------------------------------

	logic      rd_pend;  // data read waiting
	logic      rd_lock;  // read already shown to sequencer, hold it
	mem_addr_t rd_addr;

	// write buffer, entries stored already steered
	mem_addr_t  wb_addr [DEPTH];
	data_word_t wb_data [DEPTH];
	lane_mask_t wb_mask [DEPTH];
	logic [PTR_W-1:0] head;  // oldest entry
	logic [PTR_W-1:0] tail;  // next free slot
	logic [PTR_W:0]   count;

	logic       full;
	logic       push;        // accept a write this cycle
	logic       pop;         // oldest write done on the bus
	logic       rd_done;     // read granted
	logic       show_read;   // read presented instead of a write
	logic [1:0] lane;
	mem_addr_t  entry_addr;
	data_word_t entry_data;
	lane_mask_t entry_mask;

	assign full = (count == (PTR_W+1)'(DEPTH));
	// accept_n high check makes the accept a single cycle pulse
	assign push = !write_request_n && write_accept_n && !full && !req.abort;

	// read only once the buffer is empty, then held until its grant
	assign show_read = !req.abort && (rd_lock || (rd_pend && count == '0));
	assign pop       = req.grant && !show_read;
	assign rd_done   = req.grant && show_read;

	// --------------------------------------------------
	// lane steering on entry
	// --------------------------------------------------

	assign lane = dcache_address[1:0];

	always_comb begin
		if (write_size) begin // word, word aligned address
			entry_addr = dcache_address & ~mem_addr_t'(3);
			entry_data = write_data;
			entry_mask = '1;
		end else begin        // byte on lane addr[1:0]
			entry_addr = dcache_address;
			entry_data = data_word_t'(write_data[7:0]) << {lane, 3'b000};
			entry_mask = lane_mask_t'(1) << lane;
		end
	end

	// control state
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			rd_pend        <= 1'b0;
			rd_lock        <= 1'b0;
			dcache_done_n  <= 1'b1;
			write_accept_n <= 1'b1;
			head           <= '0;
			tail           <= '0;
			count          <= '0;
		end else begin
			dcache_done_n  <= 1'b1;
			write_accept_n <= !push;
			if (req.abort) begin
				rd_pend <= 1'b0; // writes stay, reads are dropped
				rd_lock <= 1'b0;
			end else if (rd_done) begin
				rd_pend       <= 1'b0;
				rd_lock       <= 1'b0;
				dcache_done_n <= 1'b0;
			end else begin
				if (!dcache_request_n && !rd_pend)
					rd_pend <= 1'b1;
				if (show_read)
					rd_lock <= 1'b1;
			end
			if (push)
				tail <= (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
			if (pop)
				head <= (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// payload, no reset
	always_ff @(posedge sys_clk) begin
		if (!dcache_request_n && !rd_pend)
			rd_addr <= dcache_address & READ_MASK;
		if (rd_done)
			dcache_dbus <= req.rdata;
		if (push) begin
			wb_addr[tail] <= entry_addr;
			wb_data[tail] <= entry_data;
			wb_mask[tail] <= entry_mask;
		end
	end

	// request towards the sequencer
	assign req.valid = show_read || (count != '0);
	assign req.write = !show_read;
	assign req.addr  = show_read ? rd_addr : wb_addr[head];
	assign req.wdata = show_read ? '0 : wb_data[head];
	assign req.mask  = show_read ? '1 : wb_mask[head];

endmodule

/* ifetch_port.sv */
// instruction fetch port: single read request holding, address alignment and done pulse
`timescale 1ns/1ns
`include "bcu_params.svh"

module ifetch_port import bcu_pkg::*; (
	input  logic       sys_clk,
	input  logic       reset,
	input  mem_addr_t  icache_address,
	input  logic       icache_request_n, // one cycle low pulse
	output logic       icache_done_n,    // one cycle low, cache_dbus valid
	output data_word_t cache_dbus,
	cache_req_if.port  req
);

	// reads go out with the low line bits cleared
	localparam mem_addr_t READ_MASK = ~mem_addr_t'((1 << `BCU_LINE_BITS) - 1);

	logic      req_pend; // read waiting for or on the bus
	mem_addr_t req_addr;

	// request state and done strobe
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			req_pend      <= 1'b0;
			icache_done_n <= 1'b1;
		end else begin
			icache_done_n <= 1'b1; // strobe lasts one cycle
			if (req.abort) begin
				req_pend <= 1'b0; // shutdown drops it, no done
			end else if (req.grant) begin
				req_pend      <= 1'b0;
				icache_done_n <= 1'b0;
			end else if (!icache_request_n && !req_pend) begin
				req_pend <= 1'b1;
			end
		end
	end

	// address and returned word
	always_ff @(posedge sys_clk) begin
		if (!icache_request_n && !req_pend)
			req_addr <= icache_address & READ_MASK;
		if (req.grant)
			cache_dbus <= req.rdata; // rdata is mem_busin in the ack cycle
	end

	// always a full word read
	assign req.valid = req_pend;
	assign req.write = 1'b0;
	assign req.addr  = req_addr;
	assign req.wdata = '0;
	assign req.mask  = '1;

endmodule

/* cache_req_if.sv */
// request interface between a cache port and the memory sequencer, with port and sequencer modports
`timescale 1ns/1ns

interface cache_req_if import bcu_pkg::*; ();

	// driven by the port, held stable until grant
	logic       valid;
	logic       write;  // 0 read, 1 write
	mem_addr_t  addr;   // already aligned or lane adjusted
	data_word_t wdata;  // lane steered write data
	lane_mask_t mask;   // byte lanes for mem_valid

	// driven by the sequencer
	logic       grant;  // one cycle, transaction done on the bus
	data_word_t rdata;  // memory read data, valid with grant
	logic       abort;  // shutdown, drop pending reads

	modport port (
		output valid,
		output write,
		output addr,
		output wdata,
		output mask,
		input  grant,
		input  rdata,
		input  abort
	);

	modport sequencer (
		input  valid,
		input  write,
		input  addr,
		input  wdata,
		input  mask,
		output grant,
		output rdata,
		output abort
	);

endinterface

/* bcu_pkg.sv */
// bus control unit package: address, data and lane mask types, command, customer and FSM enums
`include "bcu_params.svh"

package bcu_pkg;

	// --------------------------------------------------
	// vectors
	// --------------------------------------------------

	typedef logic [`BCU_ADDR_W-1:0] mem_addr_t;      // byte address
	typedef logic [`BCU_DATA_W-1:0] data_word_t;     // one bus word
	typedef logic [`BCU_DATA_W/8-1:0] lane_mask_t;   // bit n enables byte lane n

	// --------------------------------------------------
	// memory bus command
	// --------------------------------------------------

	typedef enum logic [1:0] {
		cmd_nop   = 2'b00, // bus idle
		cmd_read  = 2'b01,
		cmd_write = 2'b10
	} mem_cmd_t;

	// owner of the transaction on the memory bus
	typedef enum logic [1:0] {
		cust_none   = 2'b00,
		cust_ifetch = 2'b01, // instruction read
		cust_dread  = 2'b10, // data read
		cust_dwrite = 2'b11  // buffered write
	} customer_t;

	// sequencer FSM
	typedef enum logic [1:0] {
		seq_idle   = 2'b00, // waiting for a request
		seq_busy   = 2'b01, // one transaction on the bus
		seq_drain  = 2'b10, // shutdown, only buffered writes served
		seq_halted = 2'b11  // shutdown done, held until reset
	} seq_state_t;

endpackage

/* bcu_params.svh */
// bus control unit width, write buffer depth and read alignment macros
`ifndef BCU_PARAMS_SVH
`define BCU_PARAMS_SVH

// --------------------------------------------------
// bus widths
// --------------------------------------------------

`define BCU_ADDR_W 32 // byte address
`define BCU_DATA_W 32 // one memory bus word, 4 byte lanes

// --------------------------------------------------
// data side write buffer
// --------------------------------------------------

// entries held between writer and memory
// writer stalls on accept once all are taken
`define BCU_WBUF_DEPTH 4

// --------------------------------------------------
// read alignment
// --------------------------------------------------

// low address bits forced to zero on every read
`define BCU_LINE_BITS 4

`endif
